/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= cpuTb
RTL_TOP   ?= cpuTop
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SOME TESTS FAILED
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/alu.sv */
`timescale 1ns/1ns
module alu import cpuPkg::*; (
  input  aluOpE       op,
  input  logic [31:0] a,       // Always Y
  input  logic [31:0] b,       // Bus or immediate
  output logic [31:0] result
);

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluPassB: result = b;
      default:  result = '0;
    endcase
  end

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/1ns
module controlUnit import cpuPkg::*; (
  input  logic        clock,
  input  logic        rstN,
  input  opcodeE      opcode,   // From IR
  input  logic        memDone,  // One cycle after ack
  output ctrlSignalsS ctrl,
  output logic        halted
);

  typedef enum logic [3:0] {
    sFetch0, sFetch1, sFetch2,
    sExec1, sExec2, sExec3, sExec4,
    sMem, sMemWb, sHalt
  } phaseE;

  phaseE phase;
  phaseE phaseNext;
  aluOpE opAlu;

  // ALU function for the register-form arithmetic ops
  always_comb begin
    case (opcode)
      opSub:   opAlu = aluSub;
      opAnd:   opAlu = aluAnd;
      opOr:    opAlu = aluOr;
      default: opAlu = aluAdd;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      phase <= sFetch0;
    end else begin
      phase <= phaseNext;
    end
  end

  assign halted = (phase == sHalt);

  // ---------------------------------------------------------------------
  // Per-phase control word with one bus load per phase
  always_comb begin
    ctrl = '0;          // srcNone, selRa, aluAdd
    phaseNext = phase;
    case (phase)
      sFetch0: begin
        ctrl.busSrc = srcPc;  // MAR <- PC, PC++
        ctrl.loadMar = 1'b1;
        ctrl.incPc = 1'b1;
        phaseNext = sFetch1;
      end
      sFetch1: begin
        ctrl.memRead = 1'b1;  // Hold until the bus cycle finishes
        if (memDone) phaseNext = sFetch2;
      end
      sFetch2: begin
        ctrl.busSrc = srcMdr; // IR <- MDR
        ctrl.loadIr = 1'b1;
        phaseNext = sExec1;
      end

      sExec1: begin
        phaseNext = sFetch0;
        case (opcode)
          opLdi, opLd, opSt, opAdd, opSub, opAnd, opOr: begin
            ctrl.busSrc = srcReg; // Y <- Rb
            ctrl.regSel = selRb;
            ctrl.loadY = 1'b1;
            phaseNext = sExec2;
          end
          opJr: begin
            ctrl.busSrc = srcReg;
            ctrl.regSel = selRa;
            ctrl.loadPc = 1'b1;
          end
          opJal: begin
            ctrl.busSrc = srcPc;  // R15 <- return address
            ctrl.loadReg = 1'b1;
            ctrl.loadLink = 1'b1;
            phaseNext = sExec2;
          end
          opOut: begin
            ctrl.busSrc = srcReg;
            ctrl.regSel = selRa;
            ctrl.loadOut = 1'b1;
          end
          opHalt:  phaseNext = sHalt;
          default: phaseNext = sFetch0;  // Unknown opcode acts as nop
        endcase
      end

      sExec2: begin
        phaseNext = sFetch0;
        case (opcode)
          opLdi, opLd, opSt: begin
            ctrl.immSel = 1'b1;   // Z <- Y + imm
            ctrl.aluOp = aluAdd;
            ctrl.loadZ = 1'b1;
            if (opcode == opSt) begin
              ctrl.busSrc = srcReg;  // Free bus carries Ra into MDR
              ctrl.regSel = selRa;
              ctrl.loadMdrBus = 1'b1;
            end
            phaseNext = sExec3;
          end
          opAdd, opSub, opAnd, opOr: begin
            ctrl.busSrc = srcReg;
            ctrl.regSel = selRc;
            ctrl.aluOp = opAlu;   // Settle cycle with no load
            phaseNext = sExec3;
          end
          opJal: begin
            ctrl.busSrc = srcReg; // PC <- Ra
            ctrl.regSel = selRa;
            ctrl.loadPc = 1'b1;
          end
          default: phaseNext = sFetch0;
        endcase
      end

      sExec3: begin
        phaseNext = sFetch0;
        case (opcode)
          opLdi: begin
            ctrl.busSrc = srcZ;
            ctrl.regSel = selRa;
            ctrl.loadReg = 1'b1;
          end
          opLd, opSt: begin
            ctrl.busSrc = srcZ;   // Effective address
            ctrl.loadMar = 1'b1;
            phaseNext = sMem;
          end
          opAdd, opSub, opAnd, opOr: begin
            ctrl.busSrc = srcReg;
            ctrl.regSel = selRc;
            ctrl.aluOp = opAlu;
            ctrl.loadZ = 1'b1;
            phaseNext = sExec4;
          end
          default: phaseNext = sFetch0;
        endcase
      end

      sExec4: begin
        ctrl.busSrc = srcZ;   // Ra <- Z
        ctrl.regSel = selRa;
        ctrl.loadReg = 1'b1;
        phaseNext = sFetch0;
      end

      sMem: begin
        ctrl.memRead = (opcode == opLd);
        ctrl.memWrite = (opcode == opSt);
        if (memDone) phaseNext = (opcode == opLd) ? sMemWb : sFetch0;
      end
      sMemWb: begin
        ctrl.busSrc = srcMdr; // Ra <- loaded word
        ctrl.regSel = selRa;
        ctrl.loadReg = 1'b1;
        phaseNext = sFetch0;
      end
      sHalt:   phaseNext = sHalt;
      default: phaseNext = sFetch0;
    endcase
  end

  // Memory interface cannot serve a read and a write at once
  assert property (@(posedge clock) disable iff (!rstN) !(ctrl.memRead && ctrl.memWrite));

endmodule

/* hw/cpuPkg.sv */
package cpuPkg;

  // Opcode field in the top five bits of every instruction word
  typedef enum logic [4:0] {
    opLdi  = 5'd0,
    opLd   = 5'd1,
    opSt   = 5'd2,
    opAdd  = 5'd3,
    opSub  = 5'd4,
    opAnd  = 5'd5,
    opOr   = 5'd6,
    opJr   = 5'd7,
    opJal  = 5'd8,
    opOut  = 5'd9,
    opHalt = 5'd10
  } opcodeE;

  // Who owns the internal bus this cycle
  typedef enum logic [2:0] {
    srcNone = 3'd0, srcReg = 3'd1, srcPc = 3'd2, srcMdr = 3'd3, srcZ = 3'd4, srcImm = 3'd5
  } busSrcE;

  typedef enum logic [2:0] {
    aluAdd = 3'd0, aluSub = 3'd1, aluAnd = 3'd2, aluOr = 3'd3, aluPassB = 3'd4
  } aluOpE;

  // Register field picker (Gra/Grb/Grc)
  typedef enum logic [1:0] {
    selRa = 2'd0, selRb = 2'd1, selRc = 2'd2
  } regSelE;

  // ---------------------------------------------------------------------
  // Instruction word as the same 32 bits seen two ways
  typedef struct packed {
    opcodeE      opcode;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [14:0] unused;
  } regFormS;

  typedef struct packed {
    opcodeE      opcode;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [18:0] imm;   // Signed offset / immediate
  } immFormS;

  typedef union packed {
    regFormS regForm;
    immFormS immForm;
  } instrWordU;

  // ---------------------------------------------------------------------
  // Control word from the phase FSM for each cycle
  typedef struct packed {
    busSrcE busSrc;
    regSelE regSel;
    aluOpE  aluOp;
    logic   immSel;      // ALU B from sign-extended imm
    logic   loadPc;
    logic   incPc;
    logic   loadIr;
    logic   loadY;
    logic   loadZ;
    logic   loadMar;
    logic   loadMdrBus;  // MDR from bus (store data)
    logic   loadReg;
    logic   loadLink;    // Force R15 as write target
    logic   loadOut;
    logic   memRead;
    logic   memWrite;
  } ctrlSignalsS;

  // Wishbone classic master side
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] datW;
  } wbReqS;

  typedef struct packed {
    logic        ack;
    logic [31:0] datR;
  } wbRspS;

endpackage

/* hw/cpuTop.sv */
`timescale 1ns/1ns
module cpuTop import cpuPkg::*; #(
  parameter logic [31:0] resetPc = 32'd0
) (
  input  logic        clock,
  input  logic        rstN,
  input  wbRspS       wbRsp,
  output wbReqS       wbReq,
  output logic [31:0] outData,
  output logic        outValid,
  output logic        halted
);

  ctrlSignalsS ctrl;
  opcodeE      opcode;
  logic        memDone;
  logic        memRdValid;
  logic [31:0] memRdata;
  logic [31:0] marOut;
  logic [31:0] mdrOut;

  controlUnit ctrlInst (
    .clock(clock), .rstN(rstN), .opcode(opcode), .memDone(memDone),
    .ctrl(ctrl), .halted(halted)
  );

  datapath #(.resetPc(resetPc)) dpInst (
    .clock(clock), .rstN(rstN), .ctrl(ctrl),
    .memRdata(memRdata), .memRdValid(memRdValid),
    .opcode(opcode), .marOut(marOut), .mdrOut(mdrOut),
    .outData(outData), .outValid(outValid)
  );

  // Wishbone master shared by instructions and data
  memInterface memInst (
    .clock(clock), .rstN(rstN),
    .memRead(ctrl.memRead), .memWrite(ctrl.memWrite),
    .address(marOut), .writeData(mdrOut),
    .wbRsp(wbRsp), .wbReq(wbReq),
    .readData(memRdata), .rdValid(memRdValid), .memDone(memDone)
  );

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ns
module datapath import cpuPkg::*; #(
  parameter logic [31:0] resetPc = 32'd0
) (
  input  logic        clock,
  input  logic        rstN,
  input  ctrlSignalsS ctrl,
  input  logic [31:0] memRdata,
  input  logic        memRdValid,
  output opcodeE      opcode,
  output logic [31:0] marOut,
  output logic [31:0] mdrOut,
  output logic [31:0] outData,
  output logic        outValid
);

  logic [31:0] bus;
  logic [31:0] pc;
  logic [31:0] regData;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic [31:0] immExt;
  logic [31:0] yReg, zReg, marReg, mdrReg;
  logic [3:0]  regIdx;
  logic [3:0]  writeIdx;
  instrWordU   ir;

  // ---------------------------------------------------------------------
  // Field decode from IR
  assign opcode = ir.regForm.opcode;
  assign immExt = {{13{ir.immForm.imm[18]}}, ir.immForm.imm};

  always_comb begin
    case (ctrl.regSel)
      selRb:   regIdx = ir.regForm.rb;
      selRc:   regIdx = ir.regForm.rc;
      default: regIdx = ir.regForm.ra;
    endcase
  end

  assign writeIdx = ctrl.loadLink ? 4'd15 : regIdx;  // jal link -> R15

  // Single shared bus
  always_comb begin
    case (ctrl.busSrc)
      srcReg:  bus = regData;
      srcPc:   bus = pc;
      srcMdr:  bus = mdrReg;
      srcZ:    bus = zReg;
      srcImm:  bus = immExt;
      default: bus = '0;
    endcase
  end

  assign aluB = ctrl.immSel ? immExt : bus;

  programCounter #(.resetPc(resetPc)) pcInst (
    .clock(clock), .rstN(rstN), .incPc(ctrl.incPc), .loadPc(ctrl.loadPc),
    .busIn(bus), .pc(pc)
  );

  registerFile regFileInst (
    .clock(clock), .rstN(rstN), .readIdx(regIdx), .writeIdx(writeIdx),
    .writeEn(ctrl.loadReg), .writeData(bus), .readData(regData)
  );

  alu aluInst (.op(ctrl.aluOp), .a(yReg), .b(aluB), .result(aluResult));

  // ---------------------------------------------------------------------
  // Bus-loaded registers
  always_ff @(posedge clock) begin
    if (ctrl.loadIr) ir <= bus;
    if (ctrl.loadY) yReg <= bus;
    if (ctrl.loadZ) zReg <= aluResult;
    if (ctrl.loadMar) marReg <= bus;
    if (memRdValid) begin
      mdrReg <= memRdata;      // Read data from memory
    end else if (ctrl.loadMdrBus) begin
      mdrReg <= bus;           // Store data
    end
    if (ctrl.loadOut) outData <= bus;  // Held until next out
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= ctrl.loadOut;  // One-cycle strobe
    end
  end

  assign marOut = marReg;
  assign mdrOut = mdrReg;

endmodule

/* hw/memInterface.sv */
`timescale 1ns/1ns
module memInterface import cpuPkg::*; (
  input  logic        clock,
  input  logic        rstN,
  input  logic        memRead,
  input  logic        memWrite,
  input  logic [31:0] address,    // MAR
  input  logic [31:0] writeData,  // MDR
  input  wbRspS       wbRsp,
  output wbReqS       wbReq,
  output logic [31:0] readData,
  output logic        rdValid,
  output logic        memDone
);

  logic        cycQ;
  logic        weQ;
  logic [31:0] adrQ;
  logic [31:0] datWQ;
  logic        start;

  // Request stays up through the memDone cycle, so skip that one
  assign start = (memRead || memWrite) && !cycQ && !memDone;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      cycQ <= 1'b0;
      weQ <= 1'b0;
      memDone <= 1'b0;
      rdValid <= 1'b0;
    end else begin
      memDone <= 1'b0;
      rdValid <= 1'b0;
      if (cycQ && wbRsp.ack) begin
        cycQ <= 1'b0;        // Drop cyc/stb after the ack edge
        memDone <= 1'b1;
        rdValid <= !weQ;
      end else if (start) begin
        cycQ <= 1'b1;
        weQ <= memWrite;
      end
    end
  end

  // Address/data held for the whole cycle
  always_ff @(posedge clock) begin
    if (start) begin
      adrQ <= address;
      datWQ <= writeData;
    end
    if (cycQ && wbRsp.ack) readData <= wbRsp.datR;  // Sample on ack
  end

  assign wbReq = '{cyc: cycQ, stb: cycQ, we: weQ, adr: adrQ, datW: datWQ};

  // ---------------------------------------------------------------------
  assert property (@(posedge clock) disable iff (!rstN) wbReq.stb |-> wbReq.cyc);
  assert property (@(posedge clock) disable iff (!rstN)
    (wbReq.stb && !wbRsp.ack) |=> ($stable(wbReq.adr) && $stable(wbReq.datW)));

endmodule

/* hw/programCounter.sv */
`timescale 1ns/1ns
module programCounter import cpuPkg::*; #(
  parameter logic [31:0] resetPc = 32'd0
) (
  input  logic        clock,
  input  logic        rstN,
  input  logic        incPc,
  input  logic        loadPc,
  input  logic [31:0] busIn,
  output logic [31:0] pc
);

  // Word addressed, so one step per instruction
  always_ff @(posedge clock) begin
    if (!rstN) begin
      pc <= resetPc;         // Fetch start
    end else if (loadPc) begin
      pc <= busIn;           // Jump wins over increment
    end else if (incPc) begin
      pc <= pc + 32'd1;
    end
  end

endmodule

/* hw/registerFile.sv */
`timescale 1ns/1ns
module registerFile (
  input  logic        clock,
  input  logic        rstN,
  input  logic [3:0]  readIdx,
  input  logic [3:0]  writeIdx,
  input  logic        writeEn,
  input  logic [31:0] writeData,
  output logic [31:0] readData
);

  logic [31:0] regs [16];

  // Cleared at reset so programs see known zeros
  always_ff @(posedge clock) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeIdx != 4'd0)) begin
      regs[writeIdx] <= writeData;  // R0 is never written
    end
  end

  // R0 gated to zero on the read side as well
  assign readData = (readIdx == 4'd0) ? 32'd0 : regs[readIdx];

endmodule

/* verif/cpuTb.sv */
`timescale 1ns/1ns
module cpuTb import cpuPkg::*; ();

  localparam logic [31:0] resetPc = 32'd0;
  localparam int subAddr = 200;    // Fixed subroutine entry
  localparam int dataBase = 256;   // Data words start here
  localparam int haltLimit = 5000;

  typedef struct packed {
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } busTxnS;

  logic        clock = 1'b0;
  logic        rstN = 1'b0;
  wbRspS       wbRsp = '0;
  wbReqS       wbReq;
  logic [31:0] outData;
  logic        outValid;
  logic        halted;

  logic [31:0] mem [512];        // Memory seen by the DUT
  logic [31:0] modelMem [512];   // Reference model copy
  logic [31:0] lcgState;
  logic [31:0] expOut [$];
  busTxnS      expTxn [$];
  int          errorCount = 0;
  int          busCount, outCount, emitPc;
  int          waitLeft;
  bit          busy, prevWait;
  logic [31:0] prevAdr, prevDat;

  always #4 clock = ~clock;

  cpuTop #(.resetPc(resetPc)) cpuTop_inst (
    .clock(clock), .rstN(rstN), .wbRsp(wbRsp), .wbReq(wbReq),
    .outData(outData), .outValid(outValid), .halted(halted)
  );

  // ---------------------------------------------------------------------
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return {8'd0, lcgState[31:8]};   // Upper 24 bits of the state
  endfunction

  function automatic int randBelow(int n);
    return int'(nextRand() % n);
  endfunction

  function automatic logic [31:0] fillWord(int a);
    return 32'(a) * 32'h9E3779B1 + 32'h0137F00D;   // Hash of the full address
  endfunction

  function automatic logic [31:0] encReg(opcodeE op, int ra, int rb, int rc);
    return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
  endfunction

  function automatic logic [31:0] encImm(opcodeE op, int ra, int rb, logic [18:0] imm);
    return {op, 4'(ra), 4'(rb), imm};
  endfunction

  task automatic compareValue(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
      errorCount++;
    end
  endtask

  task automatic emit(logic [31:0] word);
    modelMem[emitPc] = word;
    emitPc++;
  endtask

  // ---------------------------------------------------------------------
  // Random program of seeded registers, mixed ops, one call and a halt
  task automatic buildProgram();
    int kind, ra, rb, rc, addr, rj;
    logic [31:0] rnd;
    opcodeE op;
    for (int a = 0; a < 512; a++) modelMem[a] = fillWord(a);
    emitPc = 0;
    repeat (6) begin
      ra = randBelow(15);            // R0 target checks the ignored write
      rb = randBelow(16);
      rnd = nextRand();
      emit(encImm(opLdi, ra, rb, rnd[18:0]));
      emit(encReg(opOut, ra, 0, 0));
    end
    for (int i = 0; i < 10; i++) begin
      if (i == 5) begin
        rj = 1 + randBelow(14);
        emit(encImm(opLdi, rj, 0, 19'(subAddr)));
        emit(encReg(opJal, rj, 0, 0));
      end
      kind = randBelow(7);
      ra = randBelow(15);
      rb = randBelow(16);
      rc = randBelow(16);
      addr = dataBase + randBelow(64);
      rnd = nextRand();
      case (kind)
        0: emit(encImm(opLdi, ra, rb, rnd[18:0]));
        1, 2, 3, 4: begin
          op = (kind == 1) ? opAdd : (kind == 2) ? opSub : (kind == 3) ? opAnd : opOr;
          emit(encReg(op, ra, rb, rc));
        end
        5: begin
          emit(encImm(opSt, rb, 0, 19'(addr)));   // Store then read back
          emit(encImm(opLd, ra, 0, 19'(addr)));
        end
        default: emit(encImm(opLd, ra, 0, 19'(addr)));  // Untouched fill word
      endcase
      emit(encReg(opOut, ra, 0, 0));
    end
    emit(encReg(opHalt, 0, 0, 0));
    modelMem[subAddr] = encReg(opOut, randBelow(16), 0, 0);
    modelMem[subAddr + 1] = encReg(opJr, 15, 0, 0);   // Return through link
  endtask

  // Reference model that fills the expected outs and bus cycles
  task automatic runModel();
    logic [31:0] regs [16];
    logic [31:0] pc, w, imm, ea;
    logic [3:0]  ra, rb, rc;
    int steps;
    bit done;
    for (int i = 0; i < 16; i++) regs[i] = '0;
    pc = resetPc;
    steps = 0;
    done = 1'b0;
    expOut.delete();
    expTxn.delete();
    while (!done && steps < 1000) begin
      w = modelMem[pc[8:0]];
      expTxn.push_back('{we: 1'b0, adr: pc, dat: 32'd0});   // Fetch
      pc = pc + 32'd1;
      steps++;
      ra = w[26:23];
      rb = w[22:19];
      rc = w[18:15];
      imm = {{13{w[18]}}, w[18:0]};
      ea = regs[rb] + imm;
      case (w[31:27])
        opLdi: if (ra != 4'd0) regs[ra] = ea;
        opAdd: if (ra != 4'd0) regs[ra] = regs[rb] + regs[rc];
        opSub: if (ra != 4'd0) regs[ra] = regs[rb] - regs[rc];
        opAnd: if (ra != 4'd0) regs[ra] = regs[rb] & regs[rc];
        opOr:  if (ra != 4'd0) regs[ra] = regs[rb] | regs[rc];
        opLd: begin
          expTxn.push_back('{we: 1'b0, adr: ea, dat: 32'd0});
          if (ra != 4'd0) regs[ra] = modelMem[ea[8:0]];
        end
        opSt: begin
          expTxn.push_back('{we: 1'b1, adr: ea, dat: regs[ra]});
          modelMem[ea[8:0]] = regs[ra];
        end
        opJr:  pc = regs[ra];
        opJal: begin
          regs[15] = pc;      // Link written before the target is read
          pc = regs[ra];
        end
        opOut:  expOut.push_back(regs[ra]);
        opHalt: done = 1'b1;
        default: ;
      endcase
    end
    if (!done) begin
      $display("Reference model did not reach halt within 1000 instructions");
      errorCount++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Wishbone slave with 0..3 random wait cycles
  always @(posedge clock) begin
    busTxnS exp;
    if (!rstN) begin
      wbRsp <= '0;
      busy = 1'b0;
      prevWait = 1'b0;
    end else begin
      if (prevWait && wbReq.stb) begin       // Held request must not move
        compareValue("wbReq.adr", prevAdr, wbReq.adr);
        compareValue("wbReq.datW", prevDat, wbReq.datW);
      end
      prevWait = wbReq.stb && !wbRsp.ack;
      prevAdr = wbReq.adr;
      prevDat = wbReq.datW;
      if (wbRsp.ack) begin
        wbRsp.ack <= 1'b0;
        busy = 1'b0;
      end else if (wbReq.cyc && wbReq.stb) begin
        if (!busy) begin
          busy = 1'b1;
          waitLeft = randBelow(4);
        end
        if (waitLeft == 0) begin
          wbRsp.ack <= 1'b1;
          wbRsp.datR <= mem[wbReq.adr[8:0]];
          if (wbReq.we) mem[wbReq.adr[8:0]] = wbReq.datW;
          busCount++;
          if (expTxn.size() == 0) begin
            $display("Unexpected bus cycle at address %h", wbReq.adr);
            errorCount++;
          end else begin
            exp = expTxn.pop_front();
            compareValue("wbReq.we", 32'(exp.we), 32'(wbReq.we));
            compareValue("wbReq.adr", exp.adr, wbReq.adr);
            if (exp.we) compareValue("wbReq.datW", exp.dat, wbReq.datW);
          end
        end else begin
          waitLeft--;
        end
      end
    end
  end

  // Output port monitor
  always @(posedge clock) begin
    if (rstN && outValid) begin
      outCount++;
      if (expOut.size() == 0) begin
        $display("Unexpected out value %h", outData);
        errorCount++;
      end else begin
        compareValue("outData", expOut.pop_front(), outData);
      end
    end
  end

  // ---------------------------------------------------------------------
  initial begin
    int errorsBefore, cycles, passed, failed;
    bit stbSeen;
    lcgState = 32'd28;
    passed = 0;
    failed = 0;
    for (int t = 0; t < 8; t++) begin
      @(posedge clock);
      rstN <= 1'b0;
      errorsBefore = errorCount;
      busCount = 0;
      outCount = 0;
      buildProgram();
      mem = modelMem;
      runModel();
      repeat (16) @(posedge clock);
      compareValue("wbReq.cyc", 32'd0, 32'(wbReq.cyc));
      compareValue("wbReq.stb", 32'd0, 32'(wbReq.stb));
      compareValue("outValid", 32'd0, 32'(outValid));
      compareValue("halted", 32'd0, 32'(halted));
      rstN <= 1'b1;
      cycles = 0;
      while (!wbReq.cyc && cycles < 20) begin   // First fetch
        @(posedge clock);
        cycles++;
      end
      if (!wbReq.cyc) begin
        $display("No bus cycle started after reset in test %0d", t);
        errorCount++;
      end else begin
        compareValue("wbReq.adr", resetPc, wbReq.adr);
      end
      cycles = 0;
      while (!halted && cycles < haltLimit) begin
        @(posedge clock);
        cycles++;
      end
      if (!halted) begin
        $display("Timed out waiting for halted in test %0d", t);
        errorCount++;
      end
      if (expOut.size() != 0) begin
        $display("%0d expected out values never appeared", expOut.size());
        errorCount++;
      end
      if (expTxn.size() != 0) begin
        $display("%0d expected bus cycles never happened", expTxn.size());
        errorCount++;
      end
      stbSeen = 1'b0;
      repeat (50) begin                         // Quiet bus after halt
        @(posedge clock);
        if (wbReq.stb) stbSeen = 1'b1;
      end
      if (stbSeen) begin
        $display("Bus strobe seen after halt in test %0d", t);
        errorCount++;
      end
      if (errorCount == errorsBefore) passed++;
      else failed++;
      $display("test %0d: %s, %0d outs, %0d bus cycles", t,
               (errorCount == errorsBefore) ? "pass" : "fail", outCount, busCount);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", passed + failed, passed, failed,
             errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
hw/cpuPkg.sv
hw/programCounter.sv
hw/registerFile.sv
hw/alu.sv
hw/memInterface.sv
hw/controlUnit.sv
hw/datapath.sv
hw/cpuTop.sv
verif/cpuTb.sv
